// File: hw/core_pkg.sv
package core_pkg;

  localparam int XLEN        = 32;
  localparam int NUM_REGS    = 32;
  localparam int QUEUE_DEPTH = 2;  // also the source's credits after reset
  localparam int CREDIT_BITS = 2;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_addr_t;

  localparam logic [6:0] OPC_OP     = 7'b0110011;  // register-register
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // register-immediate
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam instr_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    logic      reg_write;
    alu_op_e   alu_op;
    word_t     operand_a;
    word_t     operand_b;
  } ex_pkt_t;

  // memory and writeback stage contents
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    logic      reg_write;
    word_t     result;
  } res_pkt_t;

  typedef struct packed {
    reg_addr_t rd;
    word_t     data;
  } commit_t;

endpackage

// File: hw/fetch_queue.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_queue (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             in_valid,
  input  core_pkg::instr_t in_instr,
  input  logic             stall,
  output logic             out_valid,
  output core_pkg::instr_t out_instr,
  output logic             in_credit
);

  localparam int PTR_W = $clog2(core_pkg::QUEUE_DEPTH);
  localparam int CNT_W = $clog2(core_pkg::QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(core_pkg::QUEUE_DEPTH - 1);

  core_pkg::instr_t entries [core_pkg::QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  assign out_valid = (count != '0);
  assign pop       = out_valid && !stall;
  assign in_credit = pop;  // one credit back per pop
  assign out_instr = out_valid ? entries[rd_ptr] : core_pkg::NOP_INSTR;  // bubble decodes as nop

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (in_valid)
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(in_valid) - CNT_W'(pop);  // credits keep this in range
    end
  end

  always_ff @(posedge clock)
  begin
    if (in_valid)
      entries[wr_ptr] <= in_instr;
  end

endmodule

`default_nettype wire

// File: hw/decode_unit.sv
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               dec_valid,
  input  core_pkg::instr_t   dec_instr,
  input  core_pkg::res_pkt_t ex_fwd,
  input  core_pkg::res_pkt_t mem_fwd,
  input  core_pkg::res_pkt_t wb_fwd,
  input  core_pkg::res_pkt_t wb_write,
  output core_pkg::ex_pkt_t  ex_pkt
);

  core_pkg::word_t     regs [core_pkg::NUM_REGS];
  logic [6:0]          opcode;
  logic [6:0]          funct7;
  logic [2:0]          funct3;
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  core_pkg::reg_addr_t rd;
  core_pkg::word_t     imm_i;
  core_pkg::word_t     imm_u;
  core_pkg::word_t     rs1_val;
  core_pkg::word_t     rs2_val;
  core_pkg::alu_op_e   alu_op;
  logic                reg_write;
  logic                use_imm;

  // newest matching producer wins, ex over mem over wb
  function automatic core_pkg::word_t select_operand(input core_pkg::reg_addr_t rs,
                                                     input core_pkg::word_t     rf_val,
                                                     input core_pkg::res_pkt_t  ex_p,
                                                     input core_pkg::res_pkt_t  mem_p,
                                                     input core_pkg::res_pkt_t  wb_p);
    core_pkg::word_t val;
    val = rf_val;
    if (rs != '0)
    begin
      if (wb_p.valid && wb_p.reg_write && wb_p.rd == rs)
        val = wb_p.result;
      if (mem_p.valid && mem_p.reg_write && mem_p.rd == rs)
        val = mem_p.result;
      if (ex_p.valid && ex_p.reg_write && ex_p.rd == rs)
        val = ex_p.result;
    end
    return val;
  endfunction

  assign opcode = dec_instr[6:0];
  assign rd     = dec_instr[11:7];
  assign funct3 = dec_instr[14:12];
  assign rs1    = dec_instr[19:15];
  assign rs2    = dec_instr[24:20];
  assign funct7 = dec_instr[31:25];
  assign imm_i  = {{20{dec_instr[31]}}, dec_instr[31:20]};
  assign imm_u  = {dec_instr[31:12], 12'h000};

  always_comb
  begin
    alu_op    = core_pkg::ALU_ADD;
    reg_write = 1'b0;
    use_imm   = 1'b0;
    case (opcode)
      core_pkg::OPC_OP:
      begin
        reg_write = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = core_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = core_pkg::ALU_SUB;
          {7'b0000000, 3'b111}: alu_op = core_pkg::ALU_AND;
          {7'b0000000, 3'b110}: alu_op = core_pkg::ALU_OR;
          {7'b0000000, 3'b100}: alu_op = core_pkg::ALU_XOR;
          {7'b0000000, 3'b010}: alu_op = core_pkg::ALU_SLT;
          default:              reg_write = 1'b0;  // shifts, sltu
        endcase
      end
      core_pkg::OPC_OP_IMM:
      begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        case (funct3)
          3'b000:  alu_op = core_pkg::ALU_ADD;
          3'b111:  alu_op = core_pkg::ALU_AND;
          3'b110:  alu_op = core_pkg::ALU_OR;
          3'b100:  alu_op = core_pkg::ALU_XOR;
          default: reg_write = 1'b0;
        endcase
      end
      core_pkg::OPC_LUI:
      begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        alu_op    = core_pkg::ALU_PASS_B;
      end
      default: reg_write = 1'b0;  // unsupported, retires as rd 0
    endcase
  end

  assign rs1_val = select_operand(rs1, regs[rs1], ex_fwd, mem_fwd, wb_fwd);
  assign rs2_val = select_operand(rs2, regs[rs2], ex_fwd, mem_fwd, wb_fwd);

  assign ex_pkt.valid     = dec_valid;
  assign ex_pkt.rd        = reg_write ? rd : '0;
  assign ex_pkt.reg_write = reg_write;
  assign ex_pkt.alu_op    = alu_op;
  assign ex_pkt.operand_a = rs1_val;
  assign ex_pkt.operand_b = !use_imm ? rs2_val : (opcode == core_pkg::OPC_LUI) ? imm_u : imm_i;

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wb_write.valid && wb_write.reg_write && wb_write.rd != '0)
      regs[wb_write.rd] <= wb_write.result;  // x0 stays zero
  end

endmodule

`default_nettype wire

// File: hw/execution_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execution_unit (
  input  core_pkg::ex_pkt_t  ex_in,
  output core_pkg::res_pkt_t ex_out
);

  core_pkg::word_t alu_result;
  core_pkg::word_t a;
  core_pkg::word_t b;

  assign a = ex_in.operand_a;
  assign b = ex_in.operand_b;

  always_comb
  begin
    case (ex_in.alu_op)
      core_pkg::ALU_ADD:    alu_result = a + b;
      core_pkg::ALU_SUB:    alu_result = a - b;
      core_pkg::ALU_AND:    alu_result = a & b;
      core_pkg::ALU_OR:     alu_result = a | b;
      core_pkg::ALU_XOR:    alu_result = a ^ b;
      core_pkg::ALU_SLT:    alu_result = core_pkg::word_t'($signed(a) < $signed(b));
      core_pkg::ALU_PASS_B: alu_result = b;  // lui
      default:              alu_result = '0;
    endcase
  end

  assign ex_out.valid     = ex_in.valid;
  assign ex_out.rd        = ex_in.rd;
  assign ex_out.reg_write = ex_in.reg_write;
  // non-writing and x0 results retire as data 0
  assign ex_out.result    = (ex_in.reg_write && ex_in.rd != '0) ? alu_result : '0;

endmodule

`default_nettype wire

// File: hw/writeback_unit.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_unit (
  input  logic               clock,
  input  logic               rst_n,
  input  core_pkg::res_pkt_t wb_in,
  input  logic               commit_credit,
  output logic               stall,
  output core_pkg::res_pkt_t wb_write,
  output logic               commit_valid,
  output core_pkg::commit_t  commit
);

  logic [core_pkg::CREDIT_BITS-1:0] credits;
  logic                             retire;

  assign retire = wb_in.valid && (credits != '0);
  assign stall  = wb_in.valid && (credits == '0);  // entry waits for a credit

  assign commit_valid = retire;
  assign commit.rd    = wb_in.rd;
  assign commit.data  = wb_in.result;

  // register file only sees the entry in the cycle it retires
  assign wb_write.valid     = retire;
  assign wb_write.rd        = wb_in.rd;
  assign wb_write.reg_write = wb_in.reg_write && retire;
  assign wb_write.result    = wb_in.result;

  always_ff @(posedge clock)
  begin
    if (!rst_n)
      credits <= '0;  // sink grants credits after reset
    else
      credits <= credits + core_pkg::CREDIT_BITS'(commit_credit)
                         - core_pkg::CREDIT_BITS'(retire);
  end

endmodule

`default_nettype wire

// File: hw/five_stage_core.sv
`timescale 1ns/100ps
`default_nettype none

module five_stage_core (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              in_valid,
  input  core_pkg::instr_t  in_instr,
  output logic              in_credit,
  input  logic              commit_credit,
  output logic              commit_valid,
  output core_pkg::commit_t commit
);

  logic               stall;
  logic               fq_valid;
  core_pkg::instr_t   fq_instr;

  logic               dec_valid;  // decode register
  core_pkg::instr_t   dec_instr;
  core_pkg::ex_pkt_t  id_pkt;

  core_pkg::ex_pkt_t  ex_q;       // execute register
  core_pkg::res_pkt_t ex_res;
  core_pkg::res_pkt_t mem_q;      // memory register
  core_pkg::res_pkt_t wb_q;       // writeback register
  core_pkg::res_pkt_t wb_write;

  fetch_queue fq0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .stall     (stall),
    .out_valid (fq_valid),
    .out_instr (fq_instr),
    .in_credit (in_credit)
  );

  decode_unit id0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec_instr (dec_instr),
    .ex_fwd    (ex_res),
    .mem_fwd   (mem_q),
    .wb_fwd    (wb_q),
    .wb_write  (wb_write),
    .ex_pkt    (id_pkt)
  );

  execution_unit ex0 (
    .ex_in  (ex_q),
    .ex_out (ex_res)
  );

  writeback_unit wb0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .wb_in         (wb_q),
    .commit_credit (commit_credit),
    .stall         (stall),
    .wb_write      (wb_write),
    .commit_valid  (commit_valid),
    .commit        (commit)
  );

  // the whole pipe freezes together while writeback waits for a credit
  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      dec_valid   <= 1'b0;
      ex_q.valid  <= 1'b0;
      mem_q.valid <= 1'b0;
      wb_q.valid  <= 1'b0;
    end
    else if (!stall)
    begin
      dec_valid <= fq_valid;
      dec_instr <= fq_instr;
      ex_q      <= id_pkt;
      mem_q     <= ex_res;  // no data memory, just one more stage
      wb_q      <= mem_q;
    end
  end

endmodule

`default_nettype wire

// File: verification/five_stage_core_sva.sv
`timescale 1ns/100ps
`default_nettype none

module five_stage_core_sva (
  input logic clock,
  input logic rst_n,
  input logic in_valid,
  input logic in_credit,
  input logic commit_credit,
  input logic commit_valid
);

  int held;     // pushed and not yet credited back
  int credits;  // commit credits granted and not yet used

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      held    <= 0;
      credits <= 0;
    end
    else
    begin
      held    <= held + int'(in_valid) - int'(in_credit);
      credits <= credits + int'(commit_credit) - int'(commit_valid);
    end
  end

  credit_needs_entry: assert property (@(posedge clock) disable iff (!rst_n)
    in_credit |-> held > 0)
    else $error("input credit returned while the fetch queue is empty");

  commit_needs_credit: assert property (@(posedge clock) disable iff (!rst_n)
    commit_valid |-> credits > 0)
    else $error("commit raised without a commit credit");

  push_within_credit: assert property (@(posedge clock) disable iff (!rst_n)
    in_valid |-> held < core_pkg::QUEUE_DEPTH)
    else $error("source pushed beyond the queue depth");

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 5;  // 10 ns clock
  localparam int RESET_CYCLES = 5;

  initial
  begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 rst_n = 1'b1;  // released just after the edge
  end

endmodule

`default_nettype wire

// File: verification/tb_five_stage_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_five_stage_core;

  localparam int unsigned SEED              = 32'h9b66_25c1;
  localparam int          RESET_LIMIT       = 20;
  localparam int          IDLE_LIMIT        = 200;  // cycles without a commit
  localparam int          DRAIN_CYCLES      = 20;
  localparam int          COMMIT_CREDIT_MAX = (1 << core_pkg::CREDIT_BITS) - 1;

  logic              clock;
  logic              rst_n;
  logic              in_valid;
  core_pkg::instr_t  in_instr;
  logic              in_credit;
  logic              commit_credit;
  logic              commit_valid;
  core_pkg::commit_t commit;

  string             test_names [$];
  core_pkg::instr_t  test_instrs [$];
  core_pkg::commit_t test_expects [$];

  int in_credits;   // source side view of queue space
  int commit_owed;  // granted and not yet used
  int pushed;
  int popped;
  int committed;
  int idle_cycles;

  clock_gen clk0 (
    .clock (clock),
    .rst_n (rst_n)
  );

  five_stage_core dut0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_instr      (in_instr),
    .in_credit     (in_credit),
    .commit_credit (commit_credit),
    .commit_valid  (commit_valid),
    .commit        (commit)
  );

  bind five_stage_core five_stage_core_sva sva0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_credit     (in_credit),
    .commit_credit (commit_credit),
    .commit_valid  (commit_valid)
  );

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR: %s", what);
    abort_run();
  endtask

  task automatic check_commit(input string             name,
                              input core_pkg::commit_t expected,
                              input core_pkg::commit_t actual);
    if (actual !== expected)
    begin
      $display("FAILED %s: expected rd %0d data %08h, actual rd %0d data %08h",
               name, expected.rd, expected.data, actual.rd, actual.data);
      abort_run();
    end
  endtask

  task automatic load_tests();
    int                fd;
    int                fields;
    string             line;
    string             name;
    logic [31:0]       instr_val;
    logic [31:0]       rd_val;
    logic [31:0]       data_val;
    core_pkg::commit_t expected;
    fd = $fopen("verification/five_stage_core_tests.txt", "r");
    if (fd == 0)
      report_error("cannot open verification/five_stage_core_tests.txt");
    else
    begin
      while (!$feof(fd))
      begin
        line   = "";
        fields = 0;
        void'($fgets(line, fd));
        if (line.getc(0) != "#")  // skip header lines
          fields = $sscanf(line, "%s %h %h %h", name, instr_val, rd_val, data_val);
        if (fields == 4)
        begin
          expected.rd   = rd_val[4:0];
          expected.data = data_val;
          test_names.push_back(name);
          test_instrs.push_back(instr_val);
          test_expects.push_back(expected);
        end
      end
      $fclose(fd);
      if (test_names.size() == 0)
        report_error("the test file holds no tests");
    end
  endtask

  task automatic wait_for_reset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1)
    begin
      if (cycles > RESET_LIMIT)
        report_error("reset was never released");
      @(posedge clock);
      cycles++;
    end
  endtask

  task automatic drive_inputs();
    in_valid      = 1'b0;
    commit_credit = 1'b0;
    if (pushed < test_instrs.size() && in_credits > 0)
    begin
      in_valid = 1'b1;
      in_instr = test_instrs[pushed];
      pushed++;
      in_credits--;
    end
    // sparse grants so writeback stalls now and then
    if (commit_owed < COMMIT_CREDIT_MAX && ($urandom % 3) == 0)
    begin
      commit_credit = 1'b1;
      commit_owed++;
    end
  endtask

  task automatic sample_outputs();
    if (in_credit)
    begin
      popped++;
      in_credits++;
      if (in_credits > core_pkg::QUEUE_DEPTH)
        report_error("more input credits returned than instructions pushed");
    end
    if (commit_valid)
    begin
      // a grant in this cycle is usable only from the next one
      if (commit_owed - int'(commit_credit) == 0)
        report_error("commit seen without a granted commit credit");
      else if (committed >= test_expects.size())
        report_error("extra commit after the last test retired");
      else
      begin
        check_commit(test_names[committed], test_expects[committed], commit);
        committed++;
        commit_owed--;
        idle_cycles = 0;
      end
    end
  endtask

  initial
  begin : main
    in_valid      = 1'b0;
    in_instr      = core_pkg::NOP_INSTR;
    commit_credit = 1'b0;
    in_credits    = core_pkg::QUEUE_DEPTH;
    commit_owed   = 0;
    pushed        = 0;
    popped        = 0;
    committed     = 0;
    idle_cycles   = 0;
    void'($urandom(SEED));
    load_tests();
    wait_for_reset();
    while (committed < test_expects.size())
    begin
      if (idle_cycles > IDLE_LIMIT)
        report_error($sformatf("no commit within %0d cycles", IDLE_LIMIT));
      @(posedge clock);
      #1;
      drive_inputs();
      @(negedge clock);  // outputs settled mid cycle
      idle_cycles++;
      sample_outputs();
    end
    // extra cycles catch duplicated commits and stray credits
    repeat (DRAIN_CYCLES)
    begin
      @(posedge clock);
      #1;
      drive_inputs();
      @(negedge clock);
      sample_outputs();
    end
    if (popped != pushed || in_credits != core_pkg::QUEUE_DEPTH)
      report_error("input credits returned do not match the instructions popped");
    else
    begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: five_stage_core.f
hw/core_pkg.sv
hw/fetch_queue.sv
hw/decode_unit.sv
hw/execution_unit.sv
hw/writeback_unit.sv
hw/five_stage_core.sv
verification/five_stage_core_sva.sv
verification/clock_gen.sv
verification/tb_five_stage_core.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f five_stage_core.f \
  --top-module tb_five_stage_core -o sim_five_stage_core &&
./obj_dir/sim_five_stage_core ||
{ echo "simulation run ended with an error"; exit 1; }

// File: verification/five_stage_core_tests.txt
# test name, instruction word, expected rd, expected data (all hex)
# rd 00 with data 0 marks an x0 write or an unsupported opcode
addi_x1_imm          00500093 01 00000005
addi_x2_neg          FFD00113 02 FFFFFFFD
lui_x3               123451B7 03 12345000
add_x4               00208233 04 00000002
sub_x5               402082B3 05 00000008
and_x6               00317333 06 12345000
or_x7                0050E3B3 07 0000000D
xor_x8_dist1         0023C433 08 FFFFFFF0
slt_x9_neg_lt_pos    001124B3 09 00000001
slt_x10_pos_lt_neg   0080A533 0A 00000000
addi_x11_dist1       00750593 0B 00000007
ori_x12_dist1        0705E613 0C 00000077
xori_x13_dist1       FFF64693 0D FFFFFF88
andi_x14_dist1       0F06F713 0E 00000080
add_x15_dist2_dist3  00C687B3 0F FFFFFFFF
addi_x0_write        00908013 00 00000000
sw_unsupported       00112023 00 00000000
addi_x16_from_x0     12300813 10 00000123
lui_x17_min          800008B7 11 80000000
slt_x18_min_lt_pos   0108A933 12 00000001
